// ==== core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Register file and bus widths
`define REGNAME_W		6
`define FLAGS_REGNAME_W	4
`define DATA_W			32
`define FLAGS_W			5
`define PC_W			32

// Instruction fields
`define CMD_W			5
`define CC_W			4
`define TAG_W			6
`define EX_PTR_W		4

// Condition code that needs no flags operand
`define CC_AL			4'hE

// ALU0 station sizing
`define RS_ALU0_DEPTH		8

// Credits held by the execution unit at reset
`define RS_ALU0_EX_CREDITS	2

`endif

// ==== cdb_pkg.sv ====
`include "core_defs.svh"

package cdb_pkg;

	typedef logic [`REGNAME_W-1:0]			regname_t;
	typedef logic [`FLAGS_REGNAME_W-1:0]	flags_regname_t;
	typedef logic [`DATA_W-1:0]				data_t;
	typedef logic [`FLAGS_W-1:0]			flags_t;

	// Adder and mul/div channels, 15 bits
	typedef struct packed {
		logic			writeback;
		logic			flags_opt_valid;
		flags_regname_t	flags_regname;
		flags_t			flags;
		logic [3:0]		padding;
	} alu_side_t;

	// Load/store channel, writeback low on a faulting load
	typedef struct packed {
		logic			writeback;
	} ldst_side_t;

endpackage

// ==== rs_pkg.sv ====
`include "core_defs.svh"

package rs_pkg;

	typedef logic [`CMD_W-1:0]		cmd_t;
	typedef logic [`CC_W-1:0]		cc_t;
	typedef logic [`PC_W-1:0]		pc_t;
	typedef logic [`TAG_W-1:0]		commit_tag_t;
	typedef logic [`EX_PTR_W-1:0]	ex_ptr_t;

	typedef logic [$clog2(`RS_ALU0_DEPTH)-1:0]	entry_idx_t;

	// Operand fields hold a register name in the low bits while not valid
	typedef struct packed {
		cmd_t				cmd;
		cc_t				cc;
		logic				flags_valid;
		cdb_pkg::flags_t	flags;
		logic				source1_valid;
		cdb_pkg::data_t		source1;
		pc_t				pc;
		cdb_pkg::regname_t	destination_regname;
		commit_tag_t		commit_tag;
		ex_ptr_t			ex_pointer;
	} dispatch_t;

	// Record handed to the branch unit
	typedef struct packed {
		cmd_t				cmd;
		cc_t				cc;
		cdb_pkg::flags_t	flags;
		cdb_pkg::data_t		source1;
		pc_t				pc;
		cdb_pkg::regname_t	destination_regname;
		commit_tag_t		commit_tag;
	} issue_t;

endpackage

// ==== cdb_if.sv ====
interface cdb_if #(
	parameter type side_t = logic
) ();

	// Single-cycle broadcast, no handshake
	logic				valid;
	cdb_pkg::regname_t	regname;
	cdb_pkg::data_t		data;
	side_t				side;

	modport source (
		output valid,
		output regname,
		output data,
		output side
	);

	modport snoop (
		input valid,
		input regname,
		input data,
		input side
	);

endinterface

// ==== reservation_alu0_entry.sv ====
`include "core_defs.svh"

module reservation_alu0_entry (
	input  logic					iCLOCK,
	input  logic					inRESET,
	input  logic					remove,
	input  logic					issue,
	input  logic					regist_valid,
	input  rs_pkg::dispatch_t		regist,
	cdb_if.snoop					cdb_alu1,
	cdb_if.snoop					cdb_alu2,
	cdb_if.snoop					cdb_ldst,
	input  logic [`EX_PTR_W-1:0]	ex_execution_pointer,
	output logic					entry_valid,
	output logic					ready,
	output rs_pkg::issue_t			info
);

	logic						regist_en;
	cdb_pkg::regname_t			src_tag;
	cdb_pkg::flags_regname_t	flags_tag;
	logic						src_hit;
	cdb_pkg::data_t				src_data;
	logic						flags_hit;
	cdb_pkg::flags_t			flags_data;

	logic						src_valid;
	logic						flags_valid;
	logic						ptr_match;
	rs_pkg::cmd_t				cmd;
	rs_pkg::cc_t				cc;
	cdb_pkg::flags_t			flags;
	cdb_pkg::data_t				source1;
	rs_pkg::pc_t				pc;
	cdb_pkg::regname_t			destination_regname;
	rs_pkg::commit_tag_t		commit_tag;
	rs_pkg::ex_ptr_t			ex_pointer;

	assign regist_en = regist_valid && !entry_valid;

	// Tags come straight from the dispatch word while the entry is idle
	assign src_tag = entry_valid ? source1[`REGNAME_W-1:0] : regist.source1[`REGNAME_W-1:0];
	assign flags_tag = entry_valid ? flags[`FLAGS_REGNAME_W-1:0]
		: regist.flags[`FLAGS_REGNAME_W-1:0];

	// Source 1 wake-up, ALU1 first
	always_comb begin
		src_hit = 1'b1;
		src_data = '0;
		if (cdb_alu1.valid && cdb_alu1.side.writeback && cdb_alu1.regname == src_tag) begin
			src_data = cdb_alu1.data;
		end else if (cdb_alu2.valid && cdb_alu2.side.writeback
				&& cdb_alu2.regname == src_tag) begin
			src_data = cdb_alu2.data;
		end else if (cdb_ldst.valid && cdb_ldst.side.writeback
				&& cdb_ldst.regname == src_tag) begin
			src_data = cdb_ldst.data;
		end else begin
			src_hit = 1'b0;
		end
	end

	// Flags only travel on the ALU channels
	always_comb begin
		flags_hit = 1'b1;
		flags_data = '0;
		if (cdb_alu1.valid && cdb_alu1.side.flags_opt_valid
				&& cdb_alu1.side.flags_regname == flags_tag) begin
			flags_data = cdb_alu1.side.flags;
		end else if (cdb_alu2.valid && cdb_alu2.side.flags_opt_valid
				&& cdb_alu2.side.flags_regname == flags_tag) begin
			flags_data = cdb_alu2.side.flags;
		end else begin
			flags_hit = 1'b0;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			entry_valid <= 1'b0;
			src_valid <= 1'b0;
			flags_valid <= 1'b0;
			ptr_match <= 1'b0;
		end else if (issue || remove) begin
			entry_valid <= 1'b0;
			src_valid <= 1'b0;
			flags_valid <= 1'b0;
			ptr_match <= 1'b0;
		end else if (regist_en) begin
			entry_valid <= 1'b1;
			src_valid <= regist.source1_valid || src_hit;
			flags_valid <= (regist.cc == `CC_AL) || regist.flags_valid || flags_hit;
			ptr_match <= regist.ex_pointer == ex_execution_pointer;
		end else if (entry_valid) begin
			if (src_hit) begin
				src_valid <= 1'b1;
			end
			if (flags_hit) begin
				flags_valid <= 1'b1;
			end
			if (ex_pointer == ex_execution_pointer) begin
				ptr_match <= 1'b1;
			end
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (regist_en) begin
			cmd <= regist.cmd;
			cc <= regist.cc;
			pc <= regist.pc;
			destination_regname <= regist.destination_regname;
			commit_tag <= regist.commit_tag;
			ex_pointer <= regist.ex_pointer;
			// Unresolved source keeps its register name
			if (!regist.source1_valid && src_hit) begin
				source1 <= src_data;
			end else begin
				source1 <= regist.source1;
			end
			if (regist.cc == `CC_AL) begin
				flags <= '0;
			end else if (!regist.flags_valid && flags_hit) begin
				flags <= flags_data;
			end else begin
				flags <= regist.flags;
			end
		end else if (entry_valid) begin
			if (!src_valid && src_hit) begin
				source1 <= src_data;
			end
			if (!flags_valid && flags_hit) begin
				flags <= flags_data;
			end
		end
	end

	assign ready = entry_valid && flags_valid && src_valid && ptr_match;

	assign info = '{
		cmd: cmd,
		cc: cc,
		flags: flags,
		source1: source1,
		pc: pc,
		destination_regname: destination_regname,
		commit_tag: commit_tag
	};

endmodule

// ==== reservation_alu0.sv ====
`include "core_defs.svh"

module reservation_alu0 (
	input  logic					iCLOCK,
	input  logic					inRESET,
	input  logic					remove,
	input  logic					dispatch_valid,
	input  rs_pkg::dispatch_t		dispatch,
	output logic					dispatch_credit,
	cdb_if.snoop					cdb_alu1,
	cdb_if.snoop					cdb_alu2,
	cdb_if.snoop					cdb_ldst,
	input  logic [`EX_PTR_W-1:0]	ex_execution_pointer,
	input  logic					ex_credit,
	output logic					issue_valid,
	output rs_pkg::issue_t			issue
);

	localparam int DEPTH = `RS_ALU0_DEPTH;
	// One extra bit so live stamps never alias across wrap
	localparam int AGE_W = $clog2(DEPTH) + 1;
	localparam int CREDIT_W = $clog2(`RS_ALU0_EX_CREDITS + 1);

	logic [DEPTH-1:0]		entry_valid;
	logic [DEPTH-1:0]		entry_ready;
	logic [DEPTH-1:0]		entry_regist;
	logic [DEPTH-1:0]		entry_issue;
	rs_pkg::issue_t			entry_info [DEPTH];

	logic [AGE_W-1:0]		age [DEPTH];
	logic [AGE_W-1:0]		age_seq;
	logic					alloc_found;
	rs_pkg::entry_idx_t		alloc_idx;
	logic					sel_found;
	rs_pkg::entry_idx_t		sel_idx;
	logic					issue_fire;
	logic [CREDIT_W-1:0]	ex_credit_cnt;

	function automatic logic older(input logic [AGE_W-1:0] a, input logic [AGE_W-1:0] b);
		logic [AGE_W-1:0] diff;
		diff = a - b;
		return diff[AGE_W-1];
	endfunction

	for (genvar i = 0; i < DEPTH; i++) begin : g_entry
		assign entry_regist[i] = dispatch_valid && alloc_found
			&& alloc_idx == rs_pkg::entry_idx_t'(i);
		assign entry_issue[i] = issue_fire && sel_idx == rs_pkg::entry_idx_t'(i);

		reservation_alu0_entry u_entry (
			.iCLOCK					(iCLOCK),
			.inRESET				(inRESET),
			.remove					(remove),
			.issue					(entry_issue[i]),
			.regist_valid			(entry_regist[i]),
			.regist					(dispatch),
			.cdb_alu1				(cdb_alu1),
			.cdb_alu2				(cdb_alu2),
			.cdb_ldst				(cdb_ldst),
			.ex_execution_pointer	(ex_execution_pointer),
			.entry_valid			(entry_valid[i]),
			.ready					(entry_ready[i]),
			.info					(entry_info[i])
		);
	end

	// Lowest free slot
	always_comb begin
		alloc_found = 1'b0;
		alloc_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!entry_valid[i]) begin
				alloc_found = 1'b1;
				alloc_idx = rs_pkg::entry_idx_t'(i);
			end
		end
	end

	// Oldest ready entry
	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = 0; i < DEPTH; i++) begin
			if (entry_ready[i] && (!sel_found || older(age[i], age[sel_idx]))) begin
				sel_found = 1'b1;
				sel_idx = rs_pkg::entry_idx_t'(i);
			end
		end
	end

	assign issue_fire = sel_found && ex_credit_cnt != '0 && !remove;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			age_seq <= '0;
			ex_credit_cnt <= CREDIT_W'(`RS_ALU0_EX_CREDITS);
			issue_valid <= 1'b0;
			dispatch_credit <= 1'b0;
		end else begin
			if (dispatch_valid && alloc_found) begin
				age_seq <= age_seq + 1'b1;
			end
			ex_credit_cnt <= ex_credit_cnt + CREDIT_W'(ex_credit) - CREDIT_W'(issue_fire);
			issue_valid <= issue_fire;
			// One credit back for each entry freed by issue
			dispatch_credit <= |entry_issue;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (dispatch_valid && alloc_found) begin
			age[alloc_idx] <= age_seq;
		end
		if (issue_fire) begin
			issue <= entry_info[sel_idx];
		end
	end

endmodule

// ==== reservation_alu0_top.sv ====
`include "core_defs.svh"

module reservation_alu0_top (
	input  logic							iCLOCK,
	input  logic							inRESET,
	input  logic							remove,
	// Dispatch
	input  logic							dispatch_valid,
	input  logic [`CMD_W-1:0]				dispatch_cmd,
	input  logic [`CC_W-1:0]				dispatch_cc,
	input  logic							dispatch_flags_valid,
	input  logic [`FLAGS_W-1:0]				dispatch_flags,
	input  logic							dispatch_source1_valid,
	input  logic [`DATA_W-1:0]				dispatch_source1,
	input  logic [`PC_W-1:0]				dispatch_pc,
	input  logic [`REGNAME_W-1:0]			dispatch_destination_regname,
	input  logic [`TAG_W-1:0]				dispatch_commit_tag,
	input  logic [`EX_PTR_W-1:0]			dispatch_ex_pointer,
	output logic							dispatch_credit,
	// CDB adder
	input  logic							alu1_valid,
	input  logic [`REGNAME_W-1:0]			alu1_regname,
	input  logic [`DATA_W-1:0]				alu1_data,
	input  logic							alu1_writeback,
	input  logic							alu1_flags_opt_valid,
	input  logic [`FLAGS_REGNAME_W-1:0]		alu1_flags_regname,
	input  logic [`FLAGS_W-1:0]				alu1_flags,
	// CDB mul/div
	input  logic							alu2_valid,
	input  logic [`REGNAME_W-1:0]			alu2_regname,
	input  logic [`DATA_W-1:0]				alu2_data,
	input  logic							alu2_writeback,
	input  logic							alu2_flags_opt_valid,
	input  logic [`FLAGS_REGNAME_W-1:0]		alu2_flags_regname,
	input  logic [`FLAGS_W-1:0]				alu2_flags,
	// CDB load/store
	input  logic							ldst_valid,
	input  logic [`REGNAME_W-1:0]			ldst_regname,
	input  logic [`DATA_W-1:0]				ldst_data,
	input  logic							ldst_writeback,
	// Execution unit
	input  logic [`EX_PTR_W-1:0]			ex_execution_pointer,
	input  logic							ex_credit,
	output logic							issue_valid,
	output logic [`CMD_W-1:0]				issue_cmd,
	output logic [`CC_W-1:0]				issue_cc,
	output logic [`FLAGS_W-1:0]				issue_flags,
	output logic [`DATA_W-1:0]				issue_source1,
	output logic [`PC_W-1:0]				issue_pc,
	output logic [`REGNAME_W-1:0]			issue_destination_regname,
	output logic [`TAG_W-1:0]				issue_commit_tag
);

	rs_pkg::dispatch_t	dispatch;
	rs_pkg::issue_t		issue;

	cdb_if #(.side_t(cdb_pkg::alu_side_t))	cdb_alu1 ();
	cdb_if #(.side_t(cdb_pkg::alu_side_t))	cdb_alu2 ();
	cdb_if #(.side_t(cdb_pkg::ldst_side_t))	cdb_ldst ();

	assign dispatch = '{
		cmd: dispatch_cmd,
		cc: dispatch_cc,
		flags_valid: dispatch_flags_valid,
		flags: dispatch_flags,
		source1_valid: dispatch_source1_valid,
		source1: dispatch_source1,
		pc: dispatch_pc,
		destination_regname: dispatch_destination_regname,
		commit_tag: dispatch_commit_tag,
		ex_pointer: dispatch_ex_pointer
	};

	assign cdb_alu1.valid = alu1_valid;
	assign cdb_alu1.regname = alu1_regname;
	assign cdb_alu1.data = alu1_data;
	assign cdb_alu1.side = '{
		writeback: alu1_writeback,
		flags_opt_valid: alu1_flags_opt_valid,
		flags_regname: alu1_flags_regname,
		flags: alu1_flags,
		padding: '0
	};

	assign cdb_alu2.valid = alu2_valid;
	assign cdb_alu2.regname = alu2_regname;
	assign cdb_alu2.data = alu2_data;
	assign cdb_alu2.side = '{
		writeback: alu2_writeback,
		flags_opt_valid: alu2_flags_opt_valid,
		flags_regname: alu2_flags_regname,
		flags: alu2_flags,
		padding: '0
	};

	assign cdb_ldst.valid = ldst_valid;
	assign cdb_ldst.regname = ldst_regname;
	assign cdb_ldst.data = ldst_data;
	assign cdb_ldst.side = '{writeback: ldst_writeback};

	reservation_alu0 u_rs (
		.iCLOCK					(iCLOCK),
		.inRESET				(inRESET),
		.remove					(remove),
		.dispatch_valid			(dispatch_valid),
		.dispatch				(dispatch),
		.dispatch_credit		(dispatch_credit),
		.cdb_alu1				(cdb_alu1),
		.cdb_alu2				(cdb_alu2),
		.cdb_ldst				(cdb_ldst),
		.ex_execution_pointer	(ex_execution_pointer),
		.ex_credit				(ex_credit),
		.issue_valid			(issue_valid),
		.issue					(issue)
	);

	assign issue_cmd = issue.cmd;
	assign issue_cc = issue.cc;
	assign issue_flags = issue.flags;
	assign issue_source1 = issue.source1;
	assign issue_pc = issue.pc;
	assign issue_destination_regname = issue.destination_regname;
	assign issue_commit_tag = issue.commit_tag;

endmodule

// ==== tb_reservation_alu0_chk.sv ====
`include "core_defs.svh"

module tb_reservation_alu0_chk (
	input logic											iCLOCK,
	input logic											inRESET,
	input logic											remove,
	input logic											issue_valid,
	input logic											dispatch_credit,
	input logic [$clog2(`RS_ALU0_EX_CREDITS + 1)-1:0]	ex_credit_cnt
);

	timeunit 1ns;
	timeprecision 1ps;

	// An underflow wraps above the reset value
	credit_not_negative: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		ex_credit_cnt <= `RS_ALU0_EX_CREDITS)
		else $error("issue credit count out of range");

	credit_follows_issue: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		dispatch_credit == issue_valid)
		else $error("dispatch credit and issue valid differ");

	quiet_after_remove: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		remove |=> !issue_valid)
		else $error("issue left right after a remove");

endmodule

bind reservation_alu0 tb_reservation_alu0_chk u_chk (
	.iCLOCK				(iCLOCK),
	.inRESET			(inRESET),
	.remove				(remove),
	.issue_valid		(issue_valid),
	.dispatch_credit	(dispatch_credit),
	.ex_credit_cnt		(ex_credit_cnt)
);

// ==== tb_reservation_alu0.sv ====
`include "core_defs.svh"

module tb_reservation_alu0;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DEPTH = `RS_ALU0_DEPTH;
	localparam int EXC = `RS_ALU0_EX_CREDITS;
	localparam int TEST_CYCLES = 8 + 25 + 20 + (4 * DEPTH + 30) + (3 * DEPTH + 30);
	localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

	logic iCLOCK, inRESET, remove, dispatch_valid, dispatch_credit;
	logic [`CMD_W-1:0] dispatch_cmd;
	logic [`CC_W-1:0] dispatch_cc;
	logic dispatch_flags_valid, dispatch_source1_valid;
	logic [`FLAGS_W-1:0] dispatch_flags;
	logic [`DATA_W-1:0] dispatch_source1;
	logic [`PC_W-1:0] dispatch_pc;
	logic [`REGNAME_W-1:0] dispatch_destination_regname;
	logic [`TAG_W-1:0] dispatch_commit_tag;
	logic [`EX_PTR_W-1:0] dispatch_ex_pointer, ex_execution_pointer;
	logic alu1_valid, alu1_writeback, alu1_flags_opt_valid;
	logic [`REGNAME_W-1:0] alu1_regname, alu2_regname, ldst_regname;
	logic [`DATA_W-1:0] alu1_data, alu2_data, ldst_data;
	logic [`FLAGS_REGNAME_W-1:0] alu1_flags_regname, alu2_flags_regname;
	logic [`FLAGS_W-1:0] alu1_flags, alu2_flags;
	logic alu2_valid, alu2_writeback, alu2_flags_opt_valid, ldst_valid, ldst_writeback;
	logic ex_credit, issue_valid;
	logic [`CMD_W-1:0] issue_cmd;
	logic [`CC_W-1:0] issue_cc;
	logic [`FLAGS_W-1:0] issue_flags;
	logic [`DATA_W-1:0] issue_source1;
	logic [`PC_W-1:0] issue_pc;
	logic [`REGNAME_W-1:0] issue_destination_regname;
	logic [`TAG_W-1:0] issue_commit_tag;

	// Execution unit model
	logic auto_credit, credit_kick;
	rs_pkg::issue_t issue_q[$];
	int rd_idx, ret_cnt, ret_base, disp_cnt, errors, passes, fails, cycle_cnt;

	reservation_alu0_top DUT (.*);

	always #10 iCLOCK = ~iCLOCK;

	always @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ex_credit <= 1'b0;
		end else begin
			ex_credit <= (auto_credit && issue_valid) || credit_kick;
		end
	end

	always @(negedge iCLOCK) begin
		if (inRESET && issue_valid) begin
			issue_q.push_back('{issue_cmd, issue_cc, issue_flags, issue_source1, issue_pc,
				issue_destination_regname, issue_commit_tag});
		end
		if (inRESET && dispatch_credit) begin
			ret_cnt++;
		end
	end

	always @(posedge iCLOCK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("run stopped by timeout after %0d cycles", cycle_cnt);
			$display("tests failed");
			$finish;
		end
	end

	function automatic int credits_left();
		return DEPTH - disp_cnt + ret_cnt - ret_base;
	endfunction

	function automatic rs_pkg::dispatch_t make_dispatch(input rs_pkg::cc_t cc, input logic fv,
			input cdb_pkg::flags_t fl, input logic sv, input cdb_pkg::data_t src,
			input rs_pkg::ex_ptr_t ptr);
		rs_pkg::dispatch_t d;
		d.cmd = rs_pkg::cmd_t'($urandom());
		d.cc = cc;
		d.flags_valid = fv;
		d.flags = fl;
		d.source1_valid = sv;
		d.source1 = src;
		d.pc = $urandom();
		d.destination_regname = cdb_pkg::regname_t'($urandom());
		d.commit_tag = rs_pkg::commit_tag_t'($urandom());
		d.ex_pointer = ptr;
		return d;
	endfunction

	// Always-condition instructions carry no flags
	function automatic rs_pkg::issue_t expected_issue(input rs_pkg::dispatch_t d,
			input cdb_pkg::flags_t fl, input cdb_pkg::data_t src);
		rs_pkg::issue_t e;
		e.cmd = d.cmd;
		e.cc = d.cc;
		e.flags = (d.cc == `CC_AL) ? '0 : fl;
		e.source1 = src;
		e.pc = d.pc;
		e.destination_regname = d.destination_regname;
		e.commit_tag = d.commit_tag;
		return e;
	endfunction

	task automatic check_issue(input rs_pkg::issue_t got, input rs_pkg::issue_t exp);
		if (got !== exp) begin
			$display("** Error @ %0t: issue = %h, expected %h", $time, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("** Error @ %0t: %s = %b, expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("** Error @ %0t: %s = %0d, expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report(input string name, input int err0);
		if (errors == err0) begin
			passes++;
			$display("test %s: PASS", name);
		end else begin
			fails++;
			$display("test %s: FAIL with %0d errors", name, errors - err0);
		end
	endtask

	task automatic drive_dispatch(input rs_pkg::dispatch_t d);
		@(posedge iCLOCK);
		if (credits_left() <= 0) begin
			$display("dispatch attempted without a credit at %0t", $time);
			errors++;
		end
		dispatch_valid <= 1'b1;
		dispatch_cmd <= d.cmd;
		dispatch_cc <= d.cc;
		dispatch_flags_valid <= d.flags_valid;
		dispatch_flags <= d.flags;
		dispatch_source1_valid <= d.source1_valid;
		dispatch_source1 <= d.source1;
		dispatch_pc <= d.pc;
		dispatch_destination_regname <= d.destination_regname;
		dispatch_commit_tag <= d.commit_tag;
		dispatch_ex_pointer <= d.ex_pointer;
		disp_cnt++;
	endtask

	task automatic idle_dispatch();
		@(posedge iCLOCK);
		dispatch_valid <= 1'b0;
		alu1_valid <= 1'b0;
	endtask

	task automatic send_alu1(input cdb_pkg::regname_t r, input cdb_pkg::data_t data);
		@(posedge iCLOCK);
		alu1_valid <= 1'b1;
		alu1_regname <= r;
		alu1_data <= data;
		alu1_writeback <= 1'b1;
		alu1_flags_opt_valid <= 1'b0;
		@(posedge iCLOCK);
		alu1_valid <= 1'b0;
	endtask

	task automatic send_alu2_flags(input cdb_pkg::flags_regname_t f, input cdb_pkg::flags_t fl);
		@(posedge iCLOCK);
		alu2_valid <= 1'b1;
		alu2_regname <= cdb_pkg::regname_t'($urandom());
		alu2_writeback <= 1'b0;
		alu2_flags_opt_valid <= 1'b1;
		alu2_flags_regname <= f;
		alu2_flags <= fl;
		@(posedge iCLOCK);
		alu2_valid <= 1'b0;
	endtask

	task automatic send_ldst(input cdb_pkg::regname_t r, input logic wb);
		@(posedge iCLOCK);
		ldst_valid <= 1'b1;
		ldst_regname <= r;
		ldst_data <= $urandom();
		ldst_writeback <= wb;
		@(posedge iCLOCK);
		ldst_valid <= 1'b0;
	endtask

	task automatic set_pointer(input rs_pkg::ex_ptr_t p);
		@(posedge iCLOCK);
		ex_execution_pointer <= p;
	endtask

	task automatic kick_credit();
		@(posedge iCLOCK);
		credit_kick <= 1'b1;
		@(posedge iCLOCK);
		credit_kick <= 1'b0;
	endtask

	task automatic wait_issue(output rs_pkg::issue_t got, output int lat);
		bit ok;
		ok = 0;
		lat = 0;
		got = '0;
		while (lat < 20 && !ok) begin
			@(posedge iCLOCK);
			lat++;
			if (issue_q.size() > rd_idx) begin
				got = issue_q[rd_idx];
				rd_idx++;
				ok = 1;
			end
		end
		if (!ok) begin
			$display("no issue arrived within 20 cycles at %0t", $time);
			errors++;
		end
	endtask

	task automatic test_ready_dispatch();
		int err0 = errors;
		int ret0 = ret_cnt;
		int lat;
		rs_pkg::dispatch_t d;
		rs_pkg::issue_t got;
		d = make_dispatch(`CC_AL, 1'b1, 5'h1f, 1'b1, $urandom(), 4'd0);
		drive_dispatch(d);
		idle_dispatch();
		wait_issue(got, lat);
		check_issue(got, expected_issue(d, 5'h0, d.source1));
		check_count("dispatch to issue cycles", lat, 2);
		check_count("dispatch credits returned", ret_cnt - ret0, 1);
		report("ready_dispatch", err0);
	endtask

	task automatic test_wake_up();
		int err0 = errors;
		int lat;
		rs_pkg::dispatch_t d;
		rs_pkg::issue_t got;
		cdb_pkg::flags_t fl;
		cdb_pkg::data_t data;
		fl = cdb_pkg::flags_t'($urandom());
		data = $urandom();
		d = make_dispatch(4'h1, 1'b0, 5'd5, 1'b0, 32'd9, 4'd0);
		drive_dispatch(d);
		idle_dispatch();
		send_alu2_flags(4'd5, fl);
		send_ldst(6'd9, 1'b0);
		repeat (3) @(posedge iCLOCK);
		check_count("issues before source wake-up", issue_q.size() - rd_idx, 0);
		send_alu1(6'd9, data);
		wait_issue(got, lat);
		check_issue(got, expected_issue(d, fl, data));
		// Broadcast in the cycle of dispatch
		data = $urandom();
		d = make_dispatch(4'h2, 1'b1, fl, 1'b0, 32'd12, 4'd0);
		drive_dispatch(d);
		alu1_valid <= 1'b1;
		alu1_regname <= 6'd12;
		alu1_data <= data;
		alu1_writeback <= 1'b1;
		alu1_flags_opt_valid <= 1'b0;
		idle_dispatch();
		wait_issue(got, lat);
		check_issue(got, expected_issue(d, fl, data));
		report("wake_up", err0);
	endtask

	task automatic test_in_order_gate();
		int err0 = errors;
		int lat;
		rs_pkg::dispatch_t d;
		rs_pkg::issue_t got;
		set_pointer(4'd1);
		d = make_dispatch(4'h3, 1'b1, 5'h0a, 1'b1, $urandom(), 4'd3);
		drive_dispatch(d);
		idle_dispatch();
		repeat (6) @(posedge iCLOCK);
		check_count("issues with pointer mismatch", issue_q.size() - rd_idx, 0);
		set_pointer(4'd3);
		wait_issue(got, lat);
		check_issue(got, expected_issue(d, 5'h0a, d.source1));
		set_pointer(4'd0);
		report("in_order_gate", err0);
	endtask

	task automatic test_age_and_credits();
		int err0 = errors;
		int ret0 = ret_cnt;
		int lat;
		rs_pkg::dispatch_t d[DEPTH];
		rs_pkg::issue_t got;
		@(posedge iCLOCK);
		auto_credit <= 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			d[i] = make_dispatch(4'h4, 1'b1, cdb_pkg::flags_t'($urandom()), 1'b1, $urandom(), 4'd0);
			drive_dispatch(d[i]);
		end
		idle_dispatch();
		repeat (DEPTH + 4) @(posedge iCLOCK);
		check_count("issues without returned credits", issue_q.size() - rd_idx, EXC);
		check_bit("issue_valid", issue_valid, 1'b0);
		repeat (DEPTH - EXC) kick_credit();
		for (int i = 0; i < DEPTH; i++) begin
			wait_issue(got, lat);
			check_issue(got, expected_issue(d[i], d[i].flags, d[i].source1));
		end
		@(posedge iCLOCK);
		check_count("dispatch credits returned", ret_cnt - ret0, DEPTH);
		repeat (EXC) kick_credit();
		auto_credit <= 1'b1;
		repeat (3) @(posedge iCLOCK);
		report("age_and_credits", err0);
	endtask

	task automatic test_remove();
		int err0 = errors;
		int lat;
		rs_pkg::dispatch_t d[DEPTH];
		rs_pkg::issue_t got;
		for (int i = 0; i < 4; i++) begin
			d[i] = make_dispatch(4'h5, 1'b1, 5'h3, 1'b1, $urandom(), 4'd7);
			drive_dispatch(d[i]);
		end
		idle_dispatch();
		// Entries turn ready in the cycle that remove is high
		set_pointer(4'd7);
		@(posedge iCLOCK);
		remove <= 1'b1;
		@(posedge iCLOCK);
		remove <= 1'b0;
		disp_cnt = 0;
		ret_base = ret_cnt;
		repeat (6) @(posedge iCLOCK);
		check_count("issues after remove", issue_q.size() - rd_idx, 0);
		check_count("dispatch credits held", credits_left(), DEPTH);
		set_pointer(4'd0);
		for (int i = 0; i < DEPTH; i++) begin
			d[i] = make_dispatch(4'h6, 1'b1, cdb_pkg::flags_t'($urandom()), 1'b1, $urandom(), 4'd0);
			drive_dispatch(d[i]);
		end
		idle_dispatch();
		for (int i = 0; i < DEPTH; i++) begin
			wait_issue(got, lat);
			check_issue(got, expected_issue(d[i], d[i].flags, d[i].source1));
		end
		@(posedge iCLOCK);
		check_count("dispatch credits returned", ret_cnt - ret_base, DEPTH);
		report("remove", err0);
	endtask

	initial begin
		void'($urandom(32'hb38b));
		iCLOCK = 1'b0;
		inRESET = 1'b0;
		{remove, dispatch_valid, dispatch_cmd, dispatch_cc, dispatch_flags_valid} = '0;
		{dispatch_flags, dispatch_source1_valid, dispatch_source1, dispatch_pc} = '0;
		{dispatch_destination_regname, dispatch_commit_tag, dispatch_ex_pointer} = '0;
		{alu1_valid, alu1_regname, alu1_data, alu1_writeback} = '0;
		{alu1_flags_opt_valid, alu1_flags_regname, alu1_flags} = '0;
		{alu2_valid, alu2_regname, alu2_data, alu2_writeback} = '0;
		{alu2_flags_opt_valid, alu2_flags_regname, alu2_flags} = '0;
		{ldst_valid, ldst_regname, ldst_data, ldst_writeback} = '0;
		ex_execution_pointer = '0;
		auto_credit = 1'b1;
		credit_kick = 1'b0;
		{rd_idx, ret_cnt, ret_base, disp_cnt, errors, passes, fails, cycle_cnt} = '0;
		repeat (2) @(posedge iCLOCK);
		inRESET <= 1'b1;
		@(posedge iCLOCK);
		check_bit("issue_valid", issue_valid, 1'b0);
		check_bit("dispatch_credit", dispatch_credit, 1'b0);
		test_ready_dispatch();
		test_wake_up();
		test_in_order_gate();
		test_age_and_credits();
		test_remove();
		$display("%0d tests passed, %0d tests with errors, %0d errors", passes, fails, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
+incdir+.
cdb_pkg.sv
rs_pkg.sv
cdb_if.sv
reservation_alu0_entry.sv
reservation_alu0.sv
reservation_alu0_top.sv
tb_reservation_alu0_chk.sv
tb_reservation_alu0.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_reservation_alu0 \
	-o tb_sim > build.log 2>&1 \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| echo "build or simulation error, see build.log and sim.log"
grep -q "^all tests passed$" sim.log && echo "PASS" && exit 0 || echo "FAIL" && exit 1
